//--- all.f
+incdir+common
+incdir+sim
common/catcore_pkg.sv
catcore/frame_decoder.sv
catcore/instr_fifo.sv
catcore/hyper_executor.sv
logic/led_drive.sv
catcore/cat_core_top.sv
sim/tb_cat_core.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module tb_cat_core -f all.f -o tb_cat_core \
        > build.log 2>&1 \
    && ./obj_dir/tb_cat_core > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation run did not complete"; }

cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

//--- sim/tb_frames.svh
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

function automatic catcore_pkg::rx_frame_t make_status_frame(logic [7:0] cmd, logic [7:0] arg,
                                                             logic [7:0] end_byte);
    catcore_pkg::rx_frame_t f;
    f = '0;
    f.data[23:0] = {end_byte, arg, cmd};
    return f;
endfunction

// Bytes 1 to 16 carry the instruction XORed with the admin key
function automatic catcore_pkg::rx_frame_t make_priv_frame(logic [127:0] plain,
                                                           logic [7:0] end_byte);
    catcore_pkg::rx_frame_t f;
    f.data = {end_byte, plain ^ `CC_ADMIN_KEY, catcore_pkg::RX_PRIV};
    return f;
endfunction

// Opcode in byte 0, closing byte 15, arguments in bytes 14 down to 11
function automatic logic [127:0] build_instr(logic [7:0] op, logic [7:0] last, logic [31:0] args);
    return {last, args, 80'h0, op};
endfunction

// Status register after one frame
function automatic logic [7:0] next_status(logic [7:0] cur, catcore_pkg::rx_frame_t f);
    logic [7:0] s;
    logic [7:0] arg;
    logic [7:0] bit_idx;
    s = cur;
    arg = f.data[15:8];
    bit_idx = arg - "A";
    if (f.data[7:0] == "A" && f.data[23:16] == "A") begin
        if (arg >= "A" && arg <= "H") begin
            s[bit_idx[2:0]] = 1'b0;
        end else if (arg == `CC_CH_RESET) begin
            s = '1;
        end
    end
    return s;
endfunction

function automatic logic [127:0] key_table_entry(logic [3:0] addr);
    case (addr)
        4'd0: return "tabby.key.slot.0";
        4'd1: return "calico.keyslot.1";
        4'd2: return "siamese.slot.two";
        4'd3: return "manx.slot.three";
        4'd10, 4'd15: return `CC_ADMIN_KEY;
        default: return '0;
    endcase
endfunction

// No reply for a bad end byte or a closing byte that differs from the opcode
function automatic logic reply_expected(logic [127:0] plain, logic [7:0] end_byte);
    return (end_byte == "D") && (plain[127:120] == plain[7:0]);
endfunction

function automatic logic [127:0] expected_reply(logic [127:0] plain);
    case (plain[7:0])
        catcore_pkg::OP_HELLO: return "meow from core!!";
        catcore_pkg::OP_LED:   return "led set";
        catcore_pkg::OP_MEM:   return key_table_entry(plain[115:112]);
        default:               return "invalid instruct";
    endcase
endfunction

`endif

//--- sim/tb_cat_core.sv
`timescale 1ns/1ps
`include "catcore_defs.svh"

module tb_cat_core;

    localparam int reply_timeout = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   rx_valid;
    catcore_pkg::rx_frame_t rx_frame;
    logic                   tx_send;
    catcore_pkg::tx_reply_t tx_data;
    logic [`CC_LED_W-1:0]   led;

    logic [7:0] status_model;
    int         checks = 0;
    int         errors = 0;
    int         test_errors = 0;

    `include "tb_frames.svh"

    cat_core_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame),
        .tx_send  (tx_send),
        .tx_data  (tx_data),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%0t ns: %s", $time, what);
            test_errors++;
        end
    endtask

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%-16s %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic send_frame(input catcore_pkg::rx_frame_t f);
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_frame <= f;
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    // Returns on the falling edge inside a tx_send pulse, or after the timeout
    task automatic wait_reply(output logic got, output logic [127:0] text);
        int n;
        got = 1'b0;
        text = '0;
        n = 0;
        while (!got && n < reply_timeout) begin
            @(negedge clk);
            got = tx_send;
            text = tx_data.text;
            n++;
        end
    endtask

    task automatic run_priv(input logic [127:0] plain, input logic [7:0] end_byte,
                            input string what);
        logic         got;
        logic [127:0] text;
        send_frame(make_priv_frame(plain, end_byte));
        wait_reply(got, text);
        if (reply_expected(plain, end_byte)) begin
            check_true(got, {"no reply arrived in time for ", what});
            if (got) begin
                check_value(text, expected_reply(plain), what);
            end
        end else begin
            check_true(!got, {"a reply was sent for an ignored ", what});
        end
    endtask

    initial begin
        logic [7:0]   cmd;
        logic [7:0]   arg;
        logic [7:0]   end_b;
        logic [7:0]   op;
        logic [7:0]   exp_led;
        logic [7:0]   led_value;
        logic [7:0]   pwm_on;
        logic [7:0]   pwm_total;
        logic [127:0] burst [6];
        logic [127:0] replies [$];
        logic [127:0] text;
        logic         got;
        int           period;
        int           on_cnt;
        int           bad_cnt;

        void'($urandom(32'h9aa0_baf5));
        rst_n = 1'b0;
        rx_valid = 1'b0;
        rx_frame = '0;
        status_model = '1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 24; i++) begin
            cmd = "A";
            arg = "A" + 8'($urandom % 8);
            end_b = "A";
            case ($urandom % 5)
                1: arg = `CC_CH_RESET;
                2: arg = 8'($urandom);
                3: end_b = "A" ^ (8'($urandom % 255) + 8'd1);
                4: begin
                    cmd = 8'h30 + 8'($urandom % 10);
                    end_b = cmd;
                end
                default: ;
            endcase
            status_model = next_status(status_model, make_status_frame(cmd, arg, end_b));
            send_frame(make_status_frame(cmd, arg, end_b));
            @(negedge clk);
            exp_led = ~status_model;
            check_value(128'(led), 128'(exp_led), "led after status frame");
        end
        finish_test("status frames");

        for (int i = 0; i < 16; i++) begin
            op = catcore_pkg::OP_HELLO;
            arg = op;
            end_b = "D";
            case ($urandom % 4)
                1: begin
                    op = 8'h44 + 8'($urandom % 150);
                    arg = op;
                end
                2: end_b = "D" ^ (8'($urandom % 255) + 8'd1);
                3: arg = op ^ (8'($urandom % 255) + 8'd1);
                default: ;
            endcase
            run_priv(build_instr(op, arg, $urandom), end_b, "privileged frame");
        end
        finish_test("privileged");

        // Byte 14 is random, so the table address is too
        op = catcore_pkg::OP_MEM;
        for (int i = 0; i < 12; i++) begin
            run_priv(build_instr(op, op, $urandom), "D", "key table read");
        end
        finish_test("key table");

        op = catcore_pkg::OP_LED;
        for (int i = 0; i < 3; i++) begin
            led_value = 8'($urandom % 255) + 8'd1;
            pwm_total = 8'($urandom % 20) + 8'd1;
            pwm_on = 8'($urandom % (pwm_total + 4));
            run_priv(build_instr(op, op, {`CC_CH_FULL, led_value, pwm_on, pwm_total}), "D",
                     "led override");
            // Let the PWM counter settle on the new period
            repeat (2) @(negedge clk);
            period = int'(pwm_total) + 1;
            on_cnt = 0;
            bad_cnt = 0;
            for (int k = 0; k < 10 * period; k++) begin
                @(negedge clk);
                if (led == led_value) begin
                    on_cnt++;
                end else if (led != '0) begin
                    bad_cnt++;
                end
            end
            check_value(128'(bad_cnt), 128'(0), "count of samples neither off nor led_value");
            check_value(128'(on_cnt), 128'(10 * ((int'(pwm_on) < period) ? int'(pwm_on) : period)),
                        "count of lit samples");
        end
        run_priv(build_instr(op, op, {`CC_CH_OFF, 24'($urandom)}), "D", "led disable");
        @(negedge clk);
        exp_led = ~status_model;
        check_value(128'(led), 128'(exp_led), "led after override disable");
        finish_test("led override");

        for (int i = 0; i < 6; i++) begin
            op = ($urandom % 2 == 0) ? 8'(catcore_pkg::OP_HELLO) : 8'(catcore_pkg::OP_MEM);
            if ($urandom % 3 == 0) begin
                op = 8'h44 + 8'($urandom % 150);
            end
            burst[i] = build_instr(op, op, $urandom);
        end
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    @(posedge clk);
                    rx_valid <= 1'b1;
                    rx_frame <= make_priv_frame(burst[i], "D");
                end
                @(posedge clk);
                rx_valid <= 1'b0;
            end
            begin
                got = 1'b1;
                while (got) begin
                    wait_reply(got, text);
                    if (got) begin
                        replies.push_back(text);
                    end
                end
            end
        join
        check_true(replies.size() >= `CC_FIFO_DEPTH && replies.size() <= 6,
                   "the burst returned a wrong number of replies");
        for (int i = 0; i < replies.size() && i < 6; i++) begin
            check_value(replies[i], expected_reply(burst[i]), "burst reply");
        end
        finish_test("burst ordering");

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- catcore/cat_core_top.sv
`timescale 1ns/1ps
`include "catcore_defs.svh"

module cat_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx_valid,
    input  catcore_pkg::rx_frame_t rx_frame,
    output logic                   tx_send,
    output catcore_pkg::tx_reply_t tx_data,
    output logic [`CC_LED_W-1:0]   led
);

    logic                         push;
    logic [`CC_INSTR_BYTES*8-1:0] push_instr;
    logic [`CC_LED_W-1:0]         status;
    logic                         pop;
    logic                         empty;
    logic [`CC_INSTR_BYTES*8-1:0] head;
    catcore_pkg::led_cfg_t        led_cfg;

    frame_decoder i_frame_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_frame   (rx_frame),
        .push       (push),
        .push_instr (push_instr),
        .status     (status)
    );

    instr_fifo #(
        .depth (`CC_FIFO_DEPTH)
    ) i_instr_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_instr (push_instr),
        .pop        (pop),
        .head       (head),
        .empty      (empty)
    );

    hyper_executor i_hyper_executor (
        .clk     (clk),
        .rst_n   (rst_n),
        .empty   (empty),
        .head    (head),
        .pop     (pop),
        .tx_send (tx_send),
        .tx_data (tx_data),
        .led_cfg (led_cfg)
    );

    led_drive i_led_drive (
        .clk     (clk),
        .rst_n   (rst_n),
        .led_cfg (led_cfg),
        .status  (status),
        .led     (led)
    );

endmodule

//--- logic/led_drive.sv
`timescale 1ns/1ps
`include "catcore_defs.svh"

module led_drive (
    input  logic                  clk,
    input  logic                  rst_n,
    input  catcore_pkg::led_cfg_t led_cfg,
    input  logic [`CC_LED_W-1:0]  status,
    output logic [`CC_LED_W-1:0]  led
);

    logic [`CC_PWM_W-1:0] pwm_cnt;
    logic                 pwm_gate;

    // Counter covers 0 to pwm_total, so a period is pwm_total + 1 cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt  <= '0;
            pwm_gate <= 1'b0;
        end else begin
            if (pwm_cnt >= led_cfg.pwm_total) begin
                pwm_cnt <= '0;
            end else begin
                pwm_cnt <= pwm_cnt + 1'b1;
            end
            pwm_gate <= (pwm_cnt < led_cfg.pwm_on);
        end
    end

    // Status LEDs are active low in the register
    always_comb begin
        if (led_cfg.override_en) begin
            led = led_cfg.led_value & {`CC_LED_W{pwm_gate}};
        end else begin
            led = ~status;
        end
    end

endmodule

//--- catcore/hyper_executor.sv
`timescale 1ns/1ps
`include "catcore_defs.svh"

module hyper_executor (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         empty,
    input  logic [`CC_INSTR_BYTES*8-1:0] head,
    output logic                         pop,
    output logic                         tx_send,
    output catcore_pkg::tx_reply_t       tx_data,
    output catcore_pkg::led_cfg_t        led_cfg
);

    localparam logic [127:0] txt_hello   = "meow from core!!";
    localparam logic [127:0] txt_led_set = "led set";
    localparam logic [127:0] txt_invalid = "invalid instruct";

    // Key table constants for the low slots
    localparam logic [127:0] key_slot_0 = "tabby.key.slot.0";
    localparam logic [127:0] key_slot_1 = "calico.keyslot.1";
    localparam logic [127:0] key_slot_2 = "siamese.slot.two";
    localparam logic [127:0] key_slot_3 = "manx.slot.three";

    catcore_pkg::exec_state_e     state;
    logic [`CC_INSTR_BYTES*8-1:0] instr_raw;
    logic [`CC_INSTR_BYTES*8-1:0] instr_dec;
    catcore_pkg::opcode_e         opcode;
    logic                         frame_ok;
    logic [3:0]                   key_addr;
    logic [127:0]                 key_entry;

    // Take the head as soon as it shows up in idle
    assign pop = (state == catcore_pkg::ST_IDLE) && !empty;

    assign opcode   = catcore_pkg::opcode_e'(instr_dec[7:0]);
    assign frame_ok = (instr_dec[127:120] == instr_dec[7:0]);
    assign key_addr = instr_dec[115:112];

    always_comb begin
        case (key_addr)
            4'd0:    key_entry = key_slot_0;
            4'd1:    key_entry = key_slot_1;
            4'd2:    key_entry = key_slot_2;
            4'd3:    key_entry = key_slot_3;
            4'd10:   key_entry = `CC_ADMIN_KEY;
            4'd15:   key_entry = `CC_ADMIN_KEY;
            default: key_entry = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= catcore_pkg::ST_IDLE;
            tx_send <= 1'b0;
            tx_data <= '0;
            led_cfg <= '0;
        end else begin
            tx_send <= 1'b0;
            case (state)
                catcore_pkg::ST_IDLE: begin
                    if (!empty) begin
                        state <= catcore_pkg::ST_DECODE;
                    end
                end
                catcore_pkg::ST_DECODE: begin
                    state <= catcore_pkg::ST_RUN;
                end
                catcore_pkg::ST_RUN: begin
                    state <= catcore_pkg::ST_IDLE;
                    // Mismatched first and last bytes mean a bad key, stay silent
                    if (frame_ok) begin
                        tx_send <= 1'b1;
                        case (opcode)
                            catcore_pkg::OP_HELLO: begin
                                tx_data.text <= txt_hello;
                            end
                            catcore_pkg::OP_LED: begin
                                if (instr_dec[119:112] == `CC_CH_FULL) begin
                                    led_cfg.override_en <= 1'b1;
                                end else if (instr_dec[119:112] == `CC_CH_OFF) begin
                                    led_cfg.override_en <= 1'b0;
                                end
                                led_cfg.led_value <= instr_dec[111:104];
                                led_cfg.pwm_on    <= instr_dec[103:96];
                                led_cfg.pwm_total <= instr_dec[95:88];
                                tx_data.text      <= txt_led_set;
                            end
                            catcore_pkg::OP_MEM: begin
                                tx_data.text <= key_entry;
                            end
                            default: begin
                                tx_data.text <= txt_invalid;
                            end
                        endcase
                    end
                end
                default: begin
                    state <= catcore_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Instruction payload stages
    always_ff @(posedge clk) begin
        if (pop) begin
            instr_raw <= head;
        end
        if (state == catcore_pkg::ST_DECODE) begin
            instr_dec <= instr_raw ^ `CC_ADMIN_KEY;
        end
    end

endmodule

//--- catcore/instr_fifo.sv
`timescale 1ns/1ps
`include "catcore_defs.svh"

module instr_fifo #(
    parameter int depth = `CC_FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  logic [`CC_INSTR_BYTES*8-1:0] push_instr,
    input  logic                         pop,
    output logic [`CC_INSTR_BYTES*8-1:0] head,
    output logic                         empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    // Pointers wrap after this entry
    localparam logic [aw-1:0] last_slot = aw'(depth - 1);

    logic [`CC_INSTR_BYTES*8-1:0] mem [depth];
    logic [aw-1:0]                wr_ptr;
    logic [aw-1:0]                rd_ptr;
    logic [aw:0]                  count;
    logic                         full;
    logic                         do_push;
    logic                         do_pop;

    assign empty   = (count == '0);
    assign full    = (count == depth[aw:0]);
    // Pushes into a full queue are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_instr;
        end
    end

endmodule

//--- catcore/frame_decoder.sv
`timescale 1ns/1ps
`include "catcore_defs.svh"

module frame_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rx_valid,
    input  catcore_pkg::rx_frame_t       rx_frame,
    output logic                         push,
    output logic [`CC_INSTR_BYTES*8-1:0] push_instr,
    output logic [`CC_LED_W-1:0]         status
);

    // Status letters that clear a bit, "A" is bit 0
    localparam logic [7:0] first_letter = 8'h41;
    localparam logic [7:0] last_letter  = 8'h48;

    catcore_pkg::rx_cmd_e cmd;
    logic [7:0]           arg_byte;
    logic [7:0]           letter_off;
    logic                 status_end_ok;
    logic                 priv_end_ok;

    assign cmd        = catcore_pkg::rx_cmd_e'(rx_frame.data[7:0]);
    assign arg_byte   = rx_frame.data[15:8];
    assign letter_off = arg_byte - first_letter;

    // End byte must repeat the command character
    assign status_end_ok = (rx_frame.data[23:16] == rx_frame.data[7:0]);
    assign priv_end_ok   = (rx_frame.data[8*(`CC_FRAME_BYTES-1) +: 8] == rx_frame.data[7:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push   <= 1'b0;
            status <= '1;
        end else begin
            push <= 1'b0;
            if (rx_valid) begin
                case (cmd)
                    catcore_pkg::RX_STATUS: begin
                        if (status_end_ok) begin
                            if (arg_byte >= first_letter && arg_byte <= last_letter) begin
                                status[letter_off[2:0]] <= 1'b0;
                            end
                            if (arg_byte == `CC_CH_RESET) begin
                                status <= '1;
                            end
                        end
                    end
                    catcore_pkg::RX_PRIV: begin
                        if (priv_end_ok) begin
                            push <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Instruction payload is bytes 1 to 16, qualified by push
    always_ff @(posedge clk) begin
        if (rx_valid && cmd == catcore_pkg::RX_PRIV && priv_end_ok) begin
            push_instr <= rx_frame.data[8 +: `CC_INSTR_BYTES*8];
        end
    end

endmodule

//--- common/catcore_pkg.sv
`include "catcore_defs.svh"

package catcore_pkg;

    // Command character in byte 0 of a receive frame
    typedef enum logic [7:0] {
        RX_STATUS = 8'h41,
        RX_PRIV   = 8'h44
    } rx_cmd_e;

    // Opcode in byte 0 of a decrypted instruction
    typedef enum logic [7:0] {
        OP_HELLO = 8'h40,
        OP_LED   = 8'h42,
        OP_MEM   = 8'h43
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_DECODE = 2'd1,
        ST_RUN    = 2'd2
    } exec_state_e;

    // Byte k sits at bits 8k+7:8k
    typedef struct packed {
        logic [`CC_FRAME_BYTES*8-1:0] data;
    } rx_frame_t;

    typedef struct packed {
        logic                 override_en;
        logic [`CC_LED_W-1:0] led_value;
        logic [`CC_PWM_W-1:0] pwm_on;
        logic [`CC_PWM_W-1:0] pwm_total;
    } led_cfg_t;

    // Reply text, first character in the top byte
    typedef struct packed {
        logic [`CC_INSTR_BYTES*8-1:0] text;
    } tx_reply_t;

endpackage

//--- common/catcore_defs.svh
`ifndef CATCORE_DEFS_SVH
`define CATCORE_DEFS_SVH

// Frame and instruction sizes in bytes
`define CC_FRAME_BYTES 18
`define CC_INSTR_BYTES 16

// Queued privileged instructions
`define CC_FIFO_DEPTH 4

// LED bank and status register width
`define CC_LED_W 8

// PWM on and total count width
`define CC_PWM_W 8

// XOR key for privileged instructions, 16 ASCII characters
`define CC_ADMIN_KEY "purr_and_pounce!"

// Override control characters in LED instructions
`define CC_CH_FULL 8'h41
`define CC_CH_OFF 8'h42

// Restores every status bit
`define CC_CH_RESET 8'h60

`endif
